// ==== verilog.f ====
src/icache_pkg.sv
src/icache_req_stage.sv
src/icache_way_ram.sv
src/icache_ctrl.sv
src/icache_refill_axi.sv
src/icache_top.sv
dv/icache_assertions.sv
dv/icache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = icache_tb
FILELIST = verilog.f
RUN_FLAGS = +verilator+error+limit+100
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tb;
	import icache_pkg::*;

	typedef struct packed {
		logic [31:0] addr;
		logic        flush; // Flush in the cycle after acceptance.
		int          hold;  // Cycles resp_ready stays low once the response is up.
		int          ars;   // New AR transfers expected.
	} entry_t;

	localparam logic [31:0] seed = 32'h3905;
	localparam int wait_limit = 200;

	logic clk;
	logic rst;
	logic flush;
	logic req_valid;
	logic req_ready;
	fetch_req_t req;
	logic resp_valid;
	logic resp_ready;
	fetch_resp_t resp;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [2:0] arprot;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] rng = seed;
	int cyc = 0;
	int ar_count = 0;
	logic [31:0] ar_addrs [$];

	// Lines 0x100 to 0x500 all map to set 0, so they walk the victim counter.
	entry_t entries [23] = '{
		'{32'h0000_0100, 1'b0, 0, 4},
		'{32'h0000_0104, 1'b0, 0, 0},
		'{32'h0000_0108, 1'b0, 0, 0},
		'{32'h0000_010E, 1'b0, 0, 0},
		'{32'h0000_0200, 1'b0, 0, 4},
		'{32'h0000_0300, 1'b0, 0, 4},
		'{32'h0000_0400, 1'b0, 0, 4},
		'{32'h0000_0500, 1'b0, 0, 4},
		'{32'h0000_0204, 1'b0, 0, 0},
		'{32'h0000_0308, 1'b0, 0, 0},
		'{32'h0000_040C, 1'b0, 0, 0},
		'{32'h0000_0504, 1'b0, 0, 0},
		'{32'h0000_0100, 1'b0, 0, 4},
		'{32'h0000_030C, 1'b0, 0, 0},
		'{32'h0000_0200, 1'b0, 0, 4},
		'{32'h0000_0104, 1'b0, 0, 0},
		'{32'h0000_1230, 1'b0, 0, 4},
		'{32'h0000_1234, 1'b0, 4, 0},
		'{32'h0000_2340, 1'b0, 3, 4},
		'{32'h0000_0504, 1'b1, 0, 0},
		'{32'h0000_0504, 1'b0, 0, 4},
		'{32'h0000_0508, 1'b0, 0, 0},
		'{32'h0000_0100, 1'b0, 0, 4}
	};

	icache_top dut (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arprot(arprot),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Memory contents are a pure function of the byte address.
	function automatic logic [31:0] model_word(input logic [31:0] a);
		return xorshift(a ^ seed);
	endfunction

	function automatic fetch_resp_t expect_resp(input logic [31:0] a);
		fetch_resp_t r;
		r.addr = {a[31:2], 2'b00};
		r.inst = model_word(r.addr);
		return r;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp, input string name);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp)
			stop_run($sformatf("CHECK FAILED time=%0t signal=%s got=%0d expected=%0d",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp));
	endtask

	task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
	endtask

	task automatic check_prot(input logic [2:0] got, input logic [2:0] exp, input string name);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp));
	endtask

	// Returns at the falling edge after the handshake edge.
	task automatic send_req(input logic [31:0] a, output int acc_cyc);
		int t;
		t = 0;
		req.addr.raw = a;
		req_valid = 1'b1;
		#1;
		while (!req_ready) begin
			t++;
			if (t > wait_limit)
				stop_run("The DUT never accepted the fetch request.");
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		req_valid = 1'b0;
		acc_cyc = cyc;
	endtask

	task automatic wait_resp(output int resp_cyc);
		int t;
		t = 0;
		while (!resp_valid) begin
			t++;
			if (t > wait_limit)
				stop_run("No response came back from the DUT in time.");
			@(negedge clk);
		end
		resp_cyc = cyc;
	endtask

	task automatic run_entry(input entry_t e);
		fetch_resp_t exp;
		int ar_start;
		int acc_cyc;
		int resp_cyc;
		int i;
		ar_start = ar_count;
		ar_addrs.delete();
		exp = expect_resp(e.addr);
		resp_ready = (e.hold == 0);
		send_req(e.addr, acc_cyc);
		if (e.flush) begin
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
			for (i = 0; i < 20; i++) begin
				check_bit(resp_valid, 1'b0, "resp_valid");
				@(negedge clk);
			end
		end else begin
			wait_resp(resp_cyc);
			check_resp(resp, exp, "resp");
			if (e.hold == 0 && e.ars == 0)
				check_count(resp_cyc - acc_cyc, 2, "hit latency");
			if (e.hold > 0) begin
				// A second fetch to the same line queues behind the stalled one.
				req.addr.raw = e.addr + 32'd4;
				req_valid = 1'b1;
				for (i = 0; i < e.hold; i++) begin
					#1;
					check_bit(resp_valid, 1'b1, "resp_valid");
					check_resp(resp, exp, "resp");
					check_bit(req_ready, i == 0, "req_ready");
					@(negedge clk);
					req_valid = 1'b0;
				end
				resp_ready = 1'b1;
				@(negedge clk);
				wait_resp(resp_cyc);
				check_resp(resp, expect_resp(e.addr + 32'd4), "resp");
			end
			@(negedge clk);
			check_bit(resp_valid, 1'b0, "resp_valid");
		end
		check_count(ar_count - ar_start, e.ars, "AR transfers");
		if (e.ars == 4) begin
			for (i = 0; i < 4; i++)
				check_addr(ar_addrs[i], {e.addr[31:4], 4'b0000} + 32'(i * 4), "araddr");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// AXI4-Lite read slave with pseudo-random AR and R delays.
	initial begin : axi_memory
		int delay;
		int t;
		logic [31:0] addr;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = '0;
		forever begin
			@(negedge clk);
			if (arvalid) begin
				rng = xorshift(rng);
				delay = int'(rng[1:0]);
				repeat (delay) @(negedge clk);
				addr = araddr;
				check_prot(arprot, 3'b000, "arprot");
				arready = 1'b1;
				@(negedge clk);
				arready = 1'b0;
				ar_count++;
				ar_addrs.push_back(addr);
				delay = int'(rng[3:2]);
				repeat (delay) @(negedge clk);
				rdata = model_word(addr);
				rresp = rng[5:4]; // Error codes are sent too.
				rvalid = 1'b1;
				t = 0;
				while (!rready) begin
					t++;
					if (t > wait_limit)
						stop_run("The DUT never raised rready for the read data.");
					@(negedge clk);
				end
				@(negedge clk);
				rvalid = 1'b0;
			end
		end
	end

	initial begin
		rst = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b1;
		repeat (10) @(negedge clk);
		check_bit(req_ready, 1'b0, "req_ready");
		check_bit(resp_valid, 1'b0, "resp_valid");
		check_bit(arvalid, 1'b0, "arvalid");
		check_bit(rready, 1'b0, "rready");
		rst = 1'b0;
		foreach (entries[i])
			run_entry(entries[i]);
		@(negedge clk);
		if (dut.u_assert.fail_count != 0) begin
			stop_run("A bound assertion failed during the run.");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/icache_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_assertions (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire resp_valid,
	input wire resp_ready,
	input wire icache_pkg::fetch_resp_t resp,
	input wire [31:0] araddr,
	input wire arvalid,
	input wire arready,
	input wire rvalid,
	input wire rready
);

	int fail_count = 0;
	int outstanding;

	// Reads accepted on AR and not yet returned on R.
	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(arvalid && arready) - int'(rvalid && rready);
	end

	resp_held: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp))
		else begin
			fail_count++;
			$error("resp changed or vanished while the core stalled it");
		end

	ar_held: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			fail_count++;
			$error("arvalid dropped or araddr moved before arready");
		end

	one_read: assert property (@(posedge clk) disable iff (rst)
		arvalid && arready |-> outstanding == 0)
		else begin
			fail_count++;
			$error("a second read was issued while one was outstanding");
		end

	r_matched: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> outstanding == 1)
		else begin
			fail_count++;
			$error("read data was taken with no read outstanding");
		end

	flush_quiet: assert property (@(posedge clk) disable iff (rst)
		flush |=> !resp_valid)
		else begin
			fail_count++;
			$error("a response showed up right after a flush");
		end

endmodule

bind icache_top icache_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.flush(flush),
	.resp_valid(resp_valid),
	.resp_ready(resp_ready),
	.resp(resp),
	.araddr(araddr),
	.arvalid(arvalid),
	.arready(arready),
	.rvalid(rvalid),
	.rready(rready)
);

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_top (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire req_valid,
	output logic req_ready,
	input wire icache_pkg::fetch_req_t req,
	output logic resp_valid,
	input wire resp_ready,
	output icache_pkg::fetch_resp_t resp,
	output logic [31:0] araddr,
	output logic arvalid,
	input wire arready,
	output logic [2:0] arprot,
	input wire [31:0] rdata,
	input wire [1:0] rresp,
	input wire rvalid,
	output logic rready
);
	import icache_pkg::*;

	fetch_req_t stage_req;
	fetch_addr_t refill_line;
	refill_word_t refill_beat;
	logic stage_valid;
	logic stage_ready;
	logic refill_start;
	logic refill_beat_valid;
	logic refill_done;

	icache_req_stage u_req_stage (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_req(stage_req)
	);

	icache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.stage_valid(stage_valid),
		.stage_ready(stage_ready),
		.stage_req(stage_req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp),
		.refill_start(refill_start),
		.refill_line(refill_line),
		.refill_beat_valid(refill_beat_valid),
		.refill_beat(refill_beat),
		.refill_done(refill_done)
	);

	icache_refill_axi u_refill (
		.clk(clk),
		.rst(rst),
		.refill_start(refill_start),
		.refill_line(refill_line),
		.refill_beat_valid(refill_beat_valid),
		.refill_beat(refill_beat),
		.refill_done(refill_done),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arprot(arprot),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

endmodule

`default_nettype wire

// ==== src/icache_refill_axi.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_refill_axi (
	input wire clk,
	input wire rst,
	input wire refill_start,
	input wire icache_pkg::fetch_addr_t refill_line,
	output logic refill_beat_valid,
	output icache_pkg::refill_word_t refill_beat,
	output logic refill_done,
	output logic [31:0] araddr,
	output logic arvalid,
	input wire arready,
	output logic [2:0] arprot,
	input wire [31:0] rdata,
	input wire [1:0] rresp,
	input wire rvalid,
	output logic rready
);
	import icache_pkg::*;

	typedef enum logic [1:0] {s_idle, s_ar, s_r} state_t;

	state_t state;
	fetch_addr_t base;
	logic [$clog2(words_per_line)-1:0] beat;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			beat <= '0;
		end else begin
			case (state)
				s_idle: if (refill_start) begin
					state <= s_ar;
					beat <= '0;
				end
				s_ar: if (arready) state <= s_r;
				s_r: if (rvalid) begin
					state <= refill_done ? s_idle : s_ar; // One read in flight at a time.
					beat <= beat + 1'b1;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle && refill_start)
			base <= refill_line;
	end

	assign arvalid = state == s_ar;
	assign rready = state == s_r;
	assign araddr = {base.f.tag, base.f.index, beat, 2'b00};
	assign arprot = 3'b000;

	// The read response code is not checked; a failed read still hands over rdata.
	assign refill_beat_valid = rvalid && rready;
	assign refill_beat = '{word_sel: beat, data: rdata};
	assign refill_done = refill_beat_valid && beat == ($bits(beat))'(words_per_line - 1);

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire stage_valid,
	output logic stage_ready,
	input wire icache_pkg::fetch_req_t stage_req,
	output logic resp_valid,
	input wire resp_ready,
	output icache_pkg::fetch_resp_t resp,
	output logic refill_start,
	output icache_pkg::fetch_addr_t refill_line,
	input wire refill_beat_valid,
	input wire icache_pkg::refill_word_t refill_beat,
	input wire refill_done
);
	import icache_pkg::*;

	typedef enum logic [1:0] {s_run, s_refill, s_replay} state_t;

	logic [tag_bits-1:0] tag_q [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];
	logic [words_per_line*32-1:0] way_data [num_ways];
	logic [words_per_line*32-1:0] line;
	logic [num_ways-1:0] victim;
	logic [num_ways-1:0] fill_way;
	logic [num_ways-1:0] hit_now;
	logic [num_ways-1:0] lk_way;
	logic [num_ways-1:0] ram_en;
	logic [num_ways-1:0] ram_we;
	logic [$clog2(num_sets)-1:0] ram_set;
	state_t state;
	fetch_addr_t lk_addr;
	logic lk_valid;
	logic lk_hit;
	logic fill_killed;
	logic resp_free;
	logic pull;
	logic beat_we;
	logic resp_load;

	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			hit_now[w] = valid_q[w][stage_req.addr.f.index] &&
				tag_q[w][stage_req.addr.f.index] == stage_req.addr.f.tag;
		end
	end

	assign lk_hit = |lk_way;
	assign resp_free = !resp_valid || resp_ready;
	assign stage_ready = state == s_run && resp_free && (!lk_valid || lk_hit);
	assign pull = stage_valid && stage_ready;
	assign resp_load = state == s_run && lk_valid && lk_hit && resp_free;
	assign beat_we = state == s_refill && refill_beat_valid && !fill_killed;
	assign ram_set = state == s_run ? stage_req.addr.f.index : lk_addr.f.index;

	always_comb begin
		for (int w = 0; w < num_ways; w++) begin
			ram_we[w] = beat_we && fill_way[w];
			ram_en[w] = ram_we[w] || (pull && hit_now[w]) || (state == s_replay && fill_way[w]);
		end
	end

	for (genvar w = 0; w < num_ways; w++) begin : g_way
		icache_way_ram u_ram (
			.clk(clk),
			.en(ram_en[w]),
			.we(ram_we[w]),
			.set(ram_set),
			.word_sel(refill_beat.word_sel),
			.wdata(refill_beat.data),
			.rdata(way_data[w])
		);
	end

	always_comb begin
		line = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (lk_way[w])
				line = line | way_data[w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_run;
			lk_valid <= 1'b0;
			resp_valid <= 1'b0;
			refill_start <= 1'b0;
			fill_killed <= 1'b0;
			fill_way <= '0;
			victim <= num_ways'(1); // Way 0 goes first.
			for (int w = 0; w < num_ways; w++)
				valid_q[w] <= '0;
		end else begin
			refill_start <= 1'b0;
			if (resp_valid && resp_ready)
				resp_valid <= 1'b0;
			case (state)
				s_run: begin
					if (resp_load) begin
						resp_valid <= 1'b1;
						lk_valid <= 1'b0;
					end else if (lk_valid && !lk_hit) begin
						state <= s_refill;
						refill_start <= 1'b1;
						fill_way <= victim;
						fill_killed <= 1'b0;
						victim <= {victim[num_ways-2:0], victim[num_ways-1]};
						for (int w = 0; w < num_ways; w++)
							if (victim[w])
								valid_q[w][lk_addr.f.index] <= 1'b0;
					end
					if (pull)
						lk_valid <= 1'b1;
				end
				s_refill: begin
					if (refill_done) begin
						state <= fill_killed ? s_run : s_replay;
						for (int w = 0; w < num_ways; w++)
							if (fill_way[w] && !fill_killed)
								valid_q[w][lk_addr.f.index] <= 1'b1;
					end
				end
				default: state <= s_run; // Replay has issued its read.
			endcase
			if (flush) begin
				// An open refill keeps running so its beats can drain.
				lk_valid <= 1'b0;
				resp_valid <= 1'b0;
				refill_start <= 1'b0;
				fill_killed <= 1'b1;
				for (int w = 0; w < num_ways; w++)
					valid_q[w] <= '0;
				if (state != s_refill || refill_done)
					state <= s_run;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_refill && refill_done && !fill_killed) begin
			for (int w = 0; w < num_ways; w++)
				if (fill_way[w])
					tag_q[w][lk_addr.f.index] <= lk_addr.f.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (pull) begin
			lk_addr <= stage_req.addr;
			lk_way <= hit_now;
		end else if (state == s_replay) begin
			lk_way <= fill_way; // The refilled way now hits.
		end
		if (resp_load) begin
			resp.inst <= line[lk_addr.f.word*32 +: 32];
			resp.addr <= lk_addr.raw;
		end
	end

	assign refill_line.raw = {lk_addr.f.tag, lk_addr.f.index, 4'b0000};

endmodule

`default_nettype wire

// ==== src/icache_way_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_way_ram (
	input wire clk,
	input wire en,
	input wire we,
	input wire [$clog2(icache_pkg::num_sets)-1:0] set,
	input wire [$clog2(icache_pkg::words_per_line)-1:0] word_sel,
	input wire [31:0] wdata,
	output logic [icache_pkg::words_per_line*32-1:0] rdata
);
	import icache_pkg::*;

	logic [words_per_line*32-1:0] mem [num_sets];

	// Single port. A write fills one word of the line and leaves rdata as it was.
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[set][word_sel*32 +: 32] <= wdata;
			end else begin
				rdata <= mem[set]; // Whole line, one cycle after the enable.
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/icache_req_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_req_stage (
	input wire clk,
	input wire rst,
	input wire flush,
	input wire req_valid,
	output logic req_ready,
	input wire icache_pkg::fetch_req_t req,
	output logic stage_valid,
	input wire stage_ready,
	output icache_pkg::fetch_req_t stage_req
);

	logic live;
	logic take;

	// The stage opens one cycle after reset is released.
	assign req_ready = live && !flush && (!stage_valid || stage_ready);
	assign take = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			live <= 1'b0;
			stage_valid <= 1'b0;
		end else begin
			live <= 1'b1;
			if (flush)
				stage_valid <= 1'b0; // A held request is simply dropped.
			else if (take)
				stage_valid <= 1'b1;
			else if (stage_ready)
				stage_valid <= 1'b0;
		end
	end

	// Fetches are word aligned, so the low two bits carry nothing.
	always_ff @(posedge clk) begin
		if (take) begin
			stage_req.addr.raw <= {req.addr.raw[31:2], 2'b00};
		end
	end

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	localparam int num_ways = 4;
	localparam int num_sets = 16;
	localparam int words_per_line = 4;
	localparam int tag_bits = 24;

	// Field view of a fetch address. byte_off holds the byte within the word.
	typedef struct packed {
		logic [tag_bits-1:0]               tag;
		logic [$clog2(num_sets)-1:0]       index;
		logic [$clog2(words_per_line)-1:0] word;
		logic [1:0]                        byte_off;
	} addr_fields_t;

	typedef union packed {
		logic [31:0]  raw; // Plain byte address.
		addr_fields_t f;
	} fetch_addr_t;

	typedef struct packed {
		fetch_addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] addr;
	} fetch_resp_t;

	// One refill beat as it leaves the AXI side.
	typedef struct packed {
		logic [$clog2(words_per_line)-1:0] word_sel;
		logic [31:0]                       data;
	} refill_word_t;

endpackage

`default_nettype wire
